/* common/stream_consts.svh */
`ifndef STREAM_CONSTS_SVH
`define STREAM_CONSTS_SVH

// Port counts of the fabric
`define SF_NUM_INPUTS   4
`define SF_NUM_OUTPUTS  2

// Inputs that share one output, so inputs 2o and 2o+1 feed output o
`define SF_NUM_REQS     2

// Payload width, not counting the source tag
`define SF_DATAW        16

// Index width inside one group
`define SF_SEL_W        1

`endif

/* common/stream_pkg.sv */
`include "stream_consts.svh"

package stream_pkg;

    // One beat as it travels through the fabric, src is the producing input
    typedef struct packed {
        logic [`SF_DATAW-1:0]               data;
        logic [$clog2(`SF_NUM_INPUTS)-1:0]  src;
    } stream_beat_t;

    // Bundle of all input beats, index is the input number
    typedef stream_beat_t [`SF_NUM_INPUTS-1:0] stream_bus_t;

endpackage

/* common/switch_pkg.sv */
`include "stream_consts.svh"

package switch_pkg;

    typedef logic [`SF_SEL_W-1:0] sel_t;  // Group-local input index

    // One select per output, element o steers output o
    typedef sel_t [`SF_NUM_OUTPUTS-1:0] sel_vec_t;

endpackage

/* run_sim.sh */
#!/bin/sh
# Builds the stream fabric testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

verilator --binary -f stream_fabric_top.f --top-module stream_fabric_tb -Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

output=$(./obj_dir/Vstream_fabric_tb)
status=$?
printf '%s\n' "$output"

if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$output" | grep -q "^Test completed successfully$"; then
    exit 0
fi

echo "Pass message not found in simulation output"
exit 1

/* stream_fabric_top.f */
+incdir+common
common/stream_pkg.sv
common/switch_pkg.sv
verilog/skid_buffer.sv
stream_switch/rr_select.sv
stream_switch/stream_switch.sv
verilog/stream_fabric_top.sv
verification/stream_fabric_tb.sv

/* stream_switch/rr_select.sv */
`include "stream_consts.svh"

module rr_select (
    input  logic                    clk,
    input  logic                    rst_n,

    input  logic [`SF_NUM_REQS-1:0] valid_grp,
    input  logic [`SF_NUM_REQS-1:0] ready_grp,

    output switch_pkg::sel_t        sel
);
    import switch_pkg::*;

    sel_t sel_other;
    logic sel_valid;
    logic sel_fire;
    logic other_valid;
    logic move;

    // With two requesters the other one is the flipped index
    assign sel_other   = sel ^ sel_t'(1);

    assign sel_valid   = valid_grp[sel];
    assign sel_fire    = sel_valid & ready_grp[sel];
    assign other_valid = valid_grp[sel_other];

    // A valid beat that has not moved keeps the lock, so it is never withdrawn
    assign move = sel_fire | (~sel_valid & other_valid);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            sel <= '0;  // Lower input of the group
        end else if (move) begin
            sel <= sel_other;
        end
    end

endmodule

/* stream_switch/stream_switch.sv */
`include "stream_consts.svh"

module stream_switch #(
    parameter int BUFFERED = 1
) (
    input  logic                                           clk,
    input  logic                                           rst_n,

    input  switch_pkg::sel_vec_t                           sel,

    input  logic [`SF_NUM_INPUTS-1:0]                      valid_in,
    input  stream_pkg::stream_bus_t                        data_in,
    output logic [`SF_NUM_INPUTS-1:0]                      ready_in,

    output logic [`SF_NUM_OUTPUTS-1:0]                     valid_out,
    output stream_pkg::stream_beat_t [`SF_NUM_OUTPUTS-1:0] data_out,
    input  logic [`SF_NUM_OUTPUTS-1:0]                     ready_out
);
    import stream_pkg::*;
    import switch_pkg::*;

    // Selected beat of each group, ahead of the output stage
    logic         [`SF_NUM_OUTPUTS-1:0] grp_valid;
    stream_beat_t [`SF_NUM_OUTPUTS-1:0] grp_data;
    logic         [`SF_NUM_OUTPUTS-1:0] grp_ready;

    for (genvar o = 0; o < `SF_NUM_OUTPUTS; o++) begin : g_out
        logic         [`SF_NUM_REQS-1:0] req_valid;
        stream_beat_t [`SF_NUM_REQS-1:0] req_data;

        for (genvar j = 0; j < `SF_NUM_REQS; j++) begin : g_req
            localparam int II = o * `SF_NUM_REQS + j;

            assign req_valid[j] = valid_in[II];
            assign req_data[j]  = data_in[II];

            // Only the selected input ever sees ready
            assign ready_in[II] = grp_ready[o] & (sel[o] == sel_t'(j));
        end

        assign grp_valid[o] = req_valid[sel[o]];
        assign grp_data[o]  = req_data[sel[o]];

        if (BUFFERED != 0) begin : g_buf
            skid_buffer out_buffer (
                .clk       (clk),
                .rst_n     (rst_n),
                .valid_in  (grp_valid[o]),
                .data_in   (grp_data[o]),
                .ready_in  (grp_ready[o]),
                .valid_out (valid_out[o]),
                .data_out  (data_out[o]),
                .ready_out (ready_out[o])
            );
        end else begin : g_pass
            // Combinational path from the input mux to the output port
            assign valid_out[o] = grp_valid[o];
            assign data_out[o]  = grp_data[o];
            assign grp_ready[o] = ready_out[o];
        end
    end

endmodule

/* verification/stream_fabric_tb.sv */
`include "stream_consts.svh"

module stream_fabric_tb;
    import stream_pkg::*;
    import switch_pkg::*;

    // All tests together take up to about 2500 cycles, the rest is margin
    localparam int MAX_CYCLES = 4000;

    logic                               clk;
    logic                               rst_n;
    logic         [`SF_NUM_INPUTS-1:0]  valid_in;
    stream_bus_t                        data_in;
    logic         [`SF_NUM_INPUTS-1:0]  ready_in;
    logic         [`SF_NUM_OUTPUTS-1:0] valid_out;
    stream_beat_t [`SF_NUM_OUTPUTS-1:0] data_out;
    logic         [`SF_NUM_OUTPUTS-1:0] ready_out;

    // Beats accepted on each input that have not yet left an output
    stream_beat_t ref_q[`SF_NUM_INPUTS][$];
    logic [1:0]   out_log[`SF_NUM_OUTPUTS][$];  // Source of every delivered beat
    int           held[`SF_NUM_OUTPUTS] = '{0, 0};
    sel_vec_t     model_sel = '0;  // Expected round-robin choice of each group
    int           wait_run[`SF_NUM_INPUTS];
    int           max_wait[`SF_NUM_INPUTS];
    logic         stall_on;
    int           cycles = 0;
    int           checks = 0;
    int           value_errors = 0;
    int           other_errors = 0;

    stream_fabric_top dut0 (
        .clk       (clk),
        .rst_n     (rst_n),
        .valid_in  (valid_in),
        .data_in   (data_in),
        .ready_in  (ready_in),
        .valid_out (valid_out),
        .data_out  (data_out),
        .ready_out (ready_out)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic compare_bit(input logic got, input logic expected, input string name);
        checks++;
        if (got !== expected) begin
            value_errors++;
            $display("Error at time %0t: %s is %b, expected %b", $time, name, got, expected);
        end
    endtask

    task automatic compare_beat(input stream_beat_t got, input stream_beat_t expected,
                                input string name);
        checks++;
        if (got !== expected) begin
            value_errors++;
            $display("Error at time %0t: %s is data %h src %0d, expected data %h src %0d",
                     $time, name, got.data, got.src, expected.data, expected.src);
        end
    endtask

    // Offers count beats on one input, leaving a random idle cycle now and then
    task automatic send_beats(input logic [1:0] idx, input int count, input int idle_pct);
        logic fired;
        int   sent;
        fired = 1'b0;
        sent  = 0;
        while (sent < count) begin
            @(negedge clk);
            if (fired) begin
                valid_in[idx] = 1'b0;
            end
            fired = 1'b0;
            if (!valid_in[idx] && ($urandom_range(99) >= idle_pct)) begin
                data_in[idx].data = `SF_DATAW'($urandom);
                data_in[idx].src  = idx;
                valid_in[idx]     = 1'b1;
            end
            @(posedge clk);
            if (valid_in[idx] && ready_in[idx]) begin
                ref_q[idx].push_back(data_in[idx]);
                fired         = 1'b1;
                sent++;
                wait_run[idx] = 0;
            end else if (valid_in[idx]) begin
                wait_run[idx]++;
                if (wait_run[idx] > max_wait[idx]) begin
                    max_wait[idx] = wait_run[idx];
                end
            end
        end
        @(negedge clk);
        valid_in[idx] = 1'b0;
    endtask

    task automatic drive_stalls(input int busy_pct);
        while (stall_on) begin
            @(negedge clk);
            ready_out[0] = $urandom_range(99) >= busy_pct;
            ready_out[1] = $urandom_range(99) >= busy_pct;
        end
        ready_out = '1;
    endtask

    task automatic wait_drained();
        while (ref_q[0].size() + ref_q[1].size() + ref_q[2].size() + ref_q[3].size() != 0) begin
            @(negedge clk);
        end
        @(negedge clk);
    endtask

    // Samples one output and its group at a rising edge, before the flops move
    task automatic watch_output(input logic o);
        logic [1:0]   chosen;
        logic [1:0]   other;
        stream_beat_t beat;
        stream_beat_t expected;
        chosen = {o, model_sel[o]};
        other  = {o, ~model_sel[o]};
        compare_bit(ready_in[other], 1'b0, $sformatf("ready_in[%0d]", other));
        if (valid_in[chosen] && ready_in[chosen]) begin
            held[o]++;
        end
        if (valid_in[other] && ready_in[other]) begin
            held[o]++;
        end
        if (valid_out[o] && ready_out[o]) begin
            held[o]--;
            beat = data_out[o];
            out_log[o].push_back(beat.src);
            if (beat.src[1] != o) begin
                other_errors++;
                $display("Output %0d delivered a beat from input %0d outside its group",
                         o, beat.src);
            end else if (ref_q[beat.src].size() == 0) begin
                other_errors++;
                $display("Output %0d delivered a beat from input %0d that was never accepted",
                         o, beat.src);
            end else begin
                expected = ref_q[beat.src].pop_front();
                compare_beat(beat, expected, $sformatf("data_out[%0d]", o));
            end
        end
        compare_bit(held[o] <= 2, 1'b1, $sformatf("held[%0d] <= 2", o));
        // Rotate after a transfer, or leave an idle choice for a waiting partner
        if ((valid_in[chosen] && ready_in[chosen]) || (!valid_in[chosen] && valid_in[other])) begin
            model_sel[o] = ~model_sel[o];
        end
    endtask

    always @(posedge clk) begin
        if (rst_n) begin
            watch_output(1'b0);
            watch_output(1'b1);
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= MAX_CYCLES) begin
            $display("Run stopped after %0d cycles because beats stopped arriving", cycles);
            $display("Test failed");
            $finish;
        end
    end

    task automatic reset_state();
        @(negedge clk);
        compare_bit(valid_out[0], 1'b0, "valid_out[0]");
        compare_bit(valid_out[1], 1'b0, "valid_out[1]");
        compare_bit(ready_in[0], 1'b1, "ready_in[0]");
        compare_bit(ready_in[1], 1'b0, "ready_in[1]");
        compare_bit(ready_in[2], 1'b1, "ready_in[2]");
        compare_bit(ready_in[3], 1'b0, "ready_in[3]");
    endtask

    task automatic routing();
        fork
            send_beats(2'd0, 50, 40);
            send_beats(2'd1, 50, 40);
            send_beats(2'd2, 50, 40);
            send_beats(2'd3, 50, 40);
        join
        wait_drained();
    endtask

    task automatic verify_alternation(input logic o, input int base);
        compare_bit(out_log[o].size() - base == 40, 1'b1,
                    $sformatf("beat count of output %0d is 40", o));
        for (int k = base + 1; k < out_log[o].size(); k++) begin
            compare_bit(out_log[o][k] != out_log[o][k - 1], 1'b1,
                        $sformatf("src change on data_out[%0d] at beat %0d", o, k - base));
        end
    endtask

    task automatic fairness();
        int base0;
        int base1;
        base0 = out_log[0].size();
        base1 = out_log[1].size();
        fork
            send_beats(2'd0, 20, 0);
            send_beats(2'd1, 20, 0);
            send_beats(2'd2, 20, 0);
            send_beats(2'd3, 20, 0);
        join
        wait_drained();
        verify_alternation(1'b0, base0);
        verify_alternation(1'b1, base1);
    endtask

    task automatic back_pressure();
        stall_on = 1'b1;
        fork
            drive_stalls(50);
            begin
                fork
                    send_beats(2'd0, 150, 30);
                    send_beats(2'd1, 150, 30);
                    send_beats(2'd2, 150, 30);
                    send_beats(2'd3, 150, 30);
                join
                stall_on = 1'b0;
            end
        join
        wait_drained();
    endtask

    task automatic independence();
        int base1;
        base1 = out_log[1].size();
        @(negedge clk);
        ready_out = 2'b10;
        fork
            send_beats(2'd0, 20, 0);
            send_beats(2'd1, 20, 0);
            begin
                fork
                    send_beats(2'd2, 20, 0);
                    send_beats(2'd3, 20, 0);
                join
                while (ref_q[2].size() + ref_q[3].size() != 0) begin
                    @(negedge clk);
                end
                compare_bit(out_log[1].size() - base1 == 40, 1'b1, "beat count of output 1 is 40");
                compare_bit(valid_out[0], 1'b1, "valid_out[0]");
                compare_bit(ready_in[0] | ready_in[1], 1'b0, "ready_in[0] | ready_in[1]");
                ready_out[0] = 1'b1;
            end
        join
        wait_drained();
    endtask

    task automatic single_source();
        foreach (max_wait[i]) begin
            max_wait[i] = 0;
        end
        fork
            send_beats(2'd0, 6, 0);
            send_beats(2'd1, 30, 0);
            send_beats(2'd2, 30, 0);
            send_beats(2'd3, 6, 0);
        join
        wait_drained();
        compare_bit(max_wait[1] <= 1, 1'b1, "wait cycles of input 1 <= 1");
        compare_bit(max_wait[2] <= 1, 1'b1, "wait cycles of input 2 <= 1");
    endtask

    initial begin
        void'($urandom(32'h24bb));
        rst_n     = 1'b0;
        valid_in  = '0;
        data_in   = '0;
        ready_out = '1;
        stall_on  = 1'b0;
        foreach (wait_run[i]) begin
            wait_run[i] = 0;
            max_wait[i] = 0;
        end
        repeat (16) @(negedge clk);
        rst_n = 1'b1;

        reset_state();
        routing();
        fairness();
        back_pressure();
        independence();
        single_source();

        $display("Checks: %0d, value errors: %0d, other errors: %0d",
                 checks, value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

/* verilog/skid_buffer.sv */
module skid_buffer (
    input  logic                     clk,
    input  logic                     rst_n,

    input  logic                     valid_in,
    input  stream_pkg::stream_beat_t data_in,
    output logic                     ready_in,

    output logic                     valid_out,
    output stream_pkg::stream_beat_t data_out,
    input  logic                     ready_out
);
    import stream_pkg::*;

    logic         skid_valid;
    stream_beat_t skid_data;
    logic         out_free;
    logic         push;

    // Output register can take a new beat when it is empty or drains this cycle
    assign out_free = ~valid_out | ready_out;

    assign ready_in = ~skid_valid;  // Comes straight from a flop
    assign push     = valid_in & ready_in;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            valid_out  <= 1'b0;
            skid_valid <= 1'b0;
        end else begin
            if (out_free) begin
                if (skid_valid) begin
                    // The parked beat is older, so it goes first
                    valid_out  <= 1'b1;
                    skid_valid <= 1'b0;
                end else begin
                    valid_out <= push;
                end
            end else if (push) begin
                skid_valid <= 1'b1;  // Catches the beat that was in flight
            end
        end
    end

    always_ff @(posedge clk) begin
        if (out_free) begin
            if (skid_valid) begin
                data_out <= skid_data;
            end else if (push) begin
                data_out <= data_in;
            end
        end
    end

    // Input is refused while this entry is full, so it only loads at a stall
    always_ff @(posedge clk) begin
        if (!out_free && push) begin
            skid_data <= data_in;
        end
    end

endmodule

/* verilog/stream_fabric_top.sv */
`include "stream_consts.svh"

module stream_fabric_top (
    input  logic                                           clk,
    input  logic                                           rst_n,

    input  logic [`SF_NUM_INPUTS-1:0]                      valid_in,
    input  stream_pkg::stream_bus_t                        data_in,
    output logic [`SF_NUM_INPUTS-1:0]                      ready_in,

    output logic [`SF_NUM_OUTPUTS-1:0]                     valid_out,
    output stream_pkg::stream_beat_t [`SF_NUM_OUTPUTS-1:0] data_out,
    input  logic [`SF_NUM_OUTPUTS-1:0]                     ready_out
);
    import switch_pkg::*;

    sel_vec_t sel;

    // Group 0 is inputs 0 and 1
    rr_select rr_sel0 (
        .clk       (clk),
        .rst_n     (rst_n),
        .valid_grp (valid_in[1:0]),
        .ready_grp (ready_in[1:0]),
        .sel       (sel[0])
    );

    rr_select rr_sel1 (
        .clk       (clk),
        .rst_n     (rst_n),
        .valid_grp (valid_in[3:2]),
        .ready_grp (ready_in[3:2]),
        .sel       (sel[1])
    );

    stream_switch #(
        .BUFFERED (1)
    ) switch0 (
        .clk       (clk),
        .rst_n     (rst_n),
        .sel       (sel),
        .valid_in  (valid_in),
        .data_in   (data_in),
        .ready_in  (ready_in),
        .valid_out (valid_out),
        .data_out  (data_out),
        .ready_out (ready_out)
    );

endmodule
